//--- source/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

  //////////////////////////////////////////////////////////////////////
  // pixel stream types
  //////////////////////////////////////////////////////////////////////

  // screen position, 1024 by 768 max
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // rgb565: red [15:11], green [10:5], blue [4:0]
  typedef logic [15:0] pixel_t;

  //////////////////////////////////////////////////////////////////////
  // accumulation types
  //////////////////////////////////////////////////////////////////////

  // hit pixels per frame, covers a full 1024x768 frame
  typedef logic [19:0] count_t;

  // coordinate sum over a frame
  localparam int sum_w = 32;
  typedef logic [sum_w-1:0] sum_t;

  //////////////////////////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////////////////////////

  // serial divider
  typedef enum logic [1:0] {idle, shift, finish} div_state_t;

  // report combiner, holds the first color until the second arrives
  typedef enum logic [1:0] {wait_both, wait_red, wait_blue, report} combine_state_t;

endpackage

`default_nettype wire

//--- source/pixel_classifier.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_classifier #(
  parameter int unsigned red_min   = 20,
  parameter int unsigned blue_min  = 20,
  parameter int unsigned green_max = 12
) (
  input  wire logic               clk_65mhz,
  input  wire logic               sys_rst,
  input  wire logic               pixel_valid,
  input  wire tracker_pkg::pixel_t  pixel,
  input  wire tracker_pkg::hcount_t hcount,
  input  wire tracker_pkg::vcount_t vcount,
  output logic                    hit_valid,
  output logic                    red_hit,
  output logic                    blue_hit,
  output tracker_pkg::hcount_t    hit_x,
  output tracker_pkg::vcount_t    hit_y,
  output logic                    frame_boundary
);

  // channel fields of the rgb565 word
  logic [4:0] red_ch;
  logic [4:0] green_top;
  logic [4:0] blue_ch;
  logic       green_low;

  assign red_ch    = pixel[15:11];
  assign green_top = pixel[10:6];   // top five of six green bits
  assign blue_ch   = pixel[4:0];
  // markers are saturated colors, so green must stay dim
  assign green_low = (green_top < green_max);

  // control, cleared on reset
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      hit_valid      <= 1'b0;
      frame_boundary <= 1'b0;
    end else begin
      hit_valid      <= pixel_valid;
      // new frame starts at the origin pixel
      frame_boundary <= pixel_valid && (hcount == '0) && (vcount == '0);
    end
  end

  // per-pixel results and coordinates, qualified by hit_valid
  always_ff @(posedge clk_65mhz) begin
    red_hit  <= (red_ch >= red_min) && green_low;
    blue_hit <= (blue_ch >= blue_min) && green_low;
    hit_x    <= hcount;
    hit_y    <= vcount;
  end

endmodule

`default_nettype wire

//--- source/serial_divider.sv
`timescale 1ns/100ps
`default_nettype none

module serial_divider (
  input  wire logic                clk_65mhz,
  input  wire logic                sys_rst,
  input  wire logic                start,
  input  wire tracker_pkg::sum_t   dividend,
  input  wire tracker_pkg::count_t divisor,
  output tracker_pkg::sum_t        quotient,
  output logic                     done
);

  localparam int count_w = $bits(tracker_pkg::count_t);
  localparam int step_w  = $clog2(tracker_pkg::sum_w);

  tracker_pkg::div_state_t state;
  logic [step_w-1:0]       step;

  // working registers, dividend shifts out as quotient bits shift in
  tracker_pkg::sum_t       quot;
  tracker_pkg::count_t     div_q;
  logic [count_w-1:0]      rem;

  // remainder with next dividend bit, then trial subtract
  logic [count_w:0]        rem_shift;
  logic [count_w+1:0]      trial;
  logic                    fits;

  assign rem_shift = {rem, quot[tracker_pkg::sum_w-1]};
  assign trial     = {1'b0, rem_shift} - {2'b00, div_q};
  assign fits      = ~trial[count_w+1];   // no borrow

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= tracker_pkg::idle;
      step  <= '0;
    end else begin
      case (state)
        tracker_pkg::idle: begin
          if (start) begin
            state <= tracker_pkg::shift;
            step  <= '0;
          end
        end
        tracker_pkg::shift: begin
          step <= step + 1'b1;
          // one quotient bit per cycle
          if (step == step_w'(tracker_pkg::sum_w - 1)) begin
            state <= tracker_pkg::finish;
          end
        end
        default: state <= tracker_pkg::idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_65mhz) begin
    if ((state == tracker_pkg::idle) && start) begin
      // operands latched here, caller may move on
      quot  <= dividend;
      div_q <= divisor;
      rem   <= '0;
    end else if (state == tracker_pkg::shift) begin
      quot <= {quot[tracker_pkg::sum_w-2:0], fits};
      // restore on borrow, keep the shifted remainder
      rem  <= fits ? trial[count_w-1:0] : rem_shift[count_w-1:0];
    end
  end

  // floor quotient held in finish state
  assign quotient = quot;
  assign done     = (state == tracker_pkg::finish);

endmodule

`default_nettype wire

//--- source/centroid_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module centroid_tracker (
  input  wire logic                 clk_65mhz,
  input  wire logic                 sys_rst,
  input  wire logic                 hit_valid,
  input  wire logic                 hit,
  input  wire tracker_pkg::hcount_t hit_x,
  input  wire tracker_pkg::vcount_t hit_y,
  input  wire logic                 frame_boundary,
  output logic                      done,
  output logic                      found,
  output tracker_pkg::hcount_t      cx,
  output tracker_pkg::vcount_t      cy
);

  localparam int x_w = $bits(tracker_pkg::hcount_t);
  localparam int y_w = $bits(tracker_pkg::vcount_t);

  tracker_pkg::sum_t   sum_x;
  tracker_pkg::sum_t   sum_y;
  tracker_pkg::count_t count;

  logic                frame_end;
  logic                count_hit;
  logic                empty;
  logic                div_start;

  tracker_pkg::sum_t   x_quot;
  tracker_pkg::sum_t   y_quot;
  logic                x_done;
  logic                y_done;

  assign frame_end = hit_valid && frame_boundary;
  assign count_hit = hit_valid && hit;
  assign empty     = (count == '0);
  // nothing to divide on an empty frame
  assign div_start = frame_end && !empty;

  //////////////////////////////////////////////////////////////////////
  // accumulation
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (frame_end) begin
      // boundary pixel opens the new frame
      sum_x <= count_hit ? tracker_pkg::sum_t'(hit_x) : '0;
      sum_y <= count_hit ? tracker_pkg::sum_t'(hit_y) : '0;
      count <= count_hit ? tracker_pkg::count_t'(1) : '0;
    end else if (count_hit) begin
      sum_x <= sum_x + tracker_pkg::sum_t'(hit_x);
      sum_y <= sum_y + tracker_pkg::sum_t'(hit_y);
      count <= count + 1'b1;
    end
  end

  // dividers snapshot the finished frame's totals at start
  serial_divider x_div (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (sum_x),
    .divisor   (count),
    .quotient  (x_quot),
    .done      (x_done)
  );

  serial_divider y_div (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (sum_y),
    .divisor   (count),
    .quotient  (y_quot),
    .done      (y_done)
  );

  //////////////////////////////////////////////////////////////////////
  // report
  //////////////////////////////////////////////////////////////////////

  // empty frame reports right away, else when both quotients land
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      done <= 1'b0;
    end else begin
      done <= (frame_end && empty) || (x_done && y_done);
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (frame_end && empty) begin
      found <= 1'b0;
      cx    <= '0;
      cy    <= '0;
    end else if (x_done && y_done) begin
      found <= 1'b1;
      // centroid never exceeds the largest coordinate
      cx    <= x_quot[x_w-1:0];
      cy    <= y_quot[y_w-1:0];
    end
  end

endmodule

`default_nettype wire

//--- source/target_combiner.sv
`timescale 1ns/100ps
`default_nettype none

module target_combiner (
  input  wire logic                 clk_65mhz,
  input  wire logic                 sys_rst,
  input  wire logic                 red_done,
  input  wire logic                 red_found,
  input  wire tracker_pkg::hcount_t red_cx,
  input  wire tracker_pkg::vcount_t red_cy,
  input  wire logic                 blue_done,
  input  wire logic                 blue_found,
  input  wire tracker_pkg::hcount_t blue_cx,
  input  wire tracker_pkg::vcount_t blue_cy,
  output logic                      target_valid,
  output logic                      target_found,
  output tracker_pkg::hcount_t      target_x,
  output tracker_pkg::vcount_t      target_y,
  output logic                      red_found_q,
  output tracker_pkg::hcount_t      red_x,
  output tracker_pkg::vcount_t      red_y,
  output logic                      blue_found_q,
  output tracker_pkg::hcount_t      blue_x,
  output tracker_pkg::vcount_t      blue_y
);

  localparam int x_w = $bits(tracker_pkg::hcount_t);
  localparam int y_w = $bits(tracker_pkg::vcount_t);

  tracker_pkg::combine_state_t state;
  logic                        complete;

  // one extra bit so the halving floors cleanly
  logic [x_w:0]                sum_x;
  logic [y_w:0]                sum_y;

  // each tracker holds its report until its next done
  assign sum_x = {1'b0, red_cx} + {1'b0, blue_cx};
  assign sum_y = {1'b0, red_cy} + {1'b0, blue_cy};

  // second report of the frame just came in
  assign complete = ((state == tracker_pkg::wait_both) && red_done && blue_done) ||
                    ((state == tracker_pkg::wait_red) && red_done) ||
                    ((state == tracker_pkg::wait_blue) && blue_done);

  //////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= tracker_pkg::wait_both;
    end else if (complete) begin
      state <= tracker_pkg::report;
    end else begin
      case (state)
        tracker_pkg::wait_both: begin
          if (red_done) begin
            state <= tracker_pkg::wait_blue;
          end else if (blue_done) begin
            state <= tracker_pkg::wait_red;
          end
        end
        tracker_pkg::report: state <= tracker_pkg::wait_both;
        default: state <= state;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs all change together with target_valid
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_65mhz) begin
    if (complete) begin
      red_found_q  <= red_found;
      red_x        <= red_cx;
      red_y        <= red_cy;
      blue_found_q <= blue_found;
      blue_x       <= blue_cx;
      blue_y       <= blue_cy;
      // midpoint only when both markers are seen
      target_found <= red_found && blue_found;
      target_x     <= (red_found && blue_found) ? sum_x[x_w:1] : '0;
      target_y     <= (red_found && blue_found) ? sum_y[y_w:1] : '0;
    end
  end

  assign target_valid = (state == tracker_pkg::report);

endmodule

`default_nettype wire

//--- source/marker_tracker_top.sv
`timescale 1ns/100ps
`default_nettype none

module marker_tracker_top #(
  parameter int unsigned red_min   = 20,
  parameter int unsigned blue_min  = 20,
  parameter int unsigned green_max = 12
) (
  input  wire logic                 clk_65mhz,
  input  wire logic                 sys_rst,
  input  wire logic                 pixel_valid,
  input  wire tracker_pkg::pixel_t  pixel,
  input  wire tracker_pkg::hcount_t hcount,
  input  wire tracker_pkg::vcount_t vcount,
  output logic                      target_valid,
  output logic                      target_found,
  output tracker_pkg::hcount_t      target_x,
  output tracker_pkg::vcount_t      target_y,
  output logic                      red_found,
  output tracker_pkg::hcount_t      red_x,
  output tracker_pkg::vcount_t      red_y,
  output logic                      blue_found,
  output tracker_pkg::hcount_t      blue_x,
  output tracker_pkg::vcount_t      blue_y
);

  // classifier outputs, one cycle behind the pixel
  logic                 hit_valid;
  logic                 red_hit;
  logic                 blue_hit;
  tracker_pkg::hcount_t hit_x;
  tracker_pkg::vcount_t hit_y;
  logic                 frame_boundary;

  // per-color reports
  logic                 red_done;
  logic                 red_trk_found;
  tracker_pkg::hcount_t red_cx;
  tracker_pkg::vcount_t red_cy;
  logic                 blue_done;
  logic                 blue_trk_found;
  tracker_pkg::hcount_t blue_cx;
  tracker_pkg::vcount_t blue_cy;

  //////////////////////////////////////////////////////////////////////
  // classify
  //////////////////////////////////////////////////////////////////////

  pixel_classifier #(
    .red_min   (red_min),
    .blue_min  (blue_min),
    .green_max (green_max)
  ) classifier (
    .clk_65mhz      (clk_65mhz),
    .sys_rst        (sys_rst),
    .pixel_valid    (pixel_valid),
    .pixel          (pixel),
    .hcount         (hcount),
    .vcount         (vcount),
    .hit_valid      (hit_valid),
    .red_hit        (red_hit),
    .blue_hit       (blue_hit),
    .hit_x          (hit_x),
    .hit_y          (hit_y),
    .frame_boundary (frame_boundary)
  );

  //////////////////////////////////////////////////////////////////////
  // track, one per color
  //////////////////////////////////////////////////////////////////////

  centroid_tracker red_tracker (
    .clk_65mhz      (clk_65mhz),
    .sys_rst        (sys_rst),
    .hit_valid      (hit_valid),
    .hit            (red_hit),
    .hit_x          (hit_x),
    .hit_y          (hit_y),
    .frame_boundary (frame_boundary),
    .done           (red_done),
    .found          (red_trk_found),
    .cx             (red_cx),
    .cy             (red_cy)
  );

  centroid_tracker blue_tracker (
    .clk_65mhz      (clk_65mhz),
    .sys_rst        (sys_rst),
    .hit_valid      (hit_valid),
    .hit            (blue_hit),
    .hit_x          (hit_x),
    .hit_y          (hit_y),
    .frame_boundary (frame_boundary),
    .done           (blue_done),
    .found          (blue_trk_found),
    .cx             (blue_cx),
    .cy             (blue_cy)
  );

  // midpoint of the two markers
  target_combiner combiner (
    .clk_65mhz    (clk_65mhz),
    .sys_rst      (sys_rst),
    .red_done     (red_done),
    .red_found    (red_trk_found),
    .red_cx       (red_cx),
    .red_cy       (red_cy),
    .blue_done    (blue_done),
    .blue_found   (blue_trk_found),
    .blue_cx      (blue_cx),
    .blue_cy      (blue_cy),
    .target_valid (target_valid),
    .target_found (target_found),
    .target_x     (target_x),
    .target_y     (target_y),
    .red_found_q  (red_found),
    .red_x        (red_x),
    .red_y        (red_y),
    .blue_found_q (blue_found),
    .blue_x       (blue_x),
    .blue_y       (blue_y)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned period_ns    = 4,
  parameter int unsigned reset_cycles = 5
) (
  output logic clk_65mhz,
  output logic sys_rst
);

  // free running, first rising edge half a period in
  initial begin
    clk_65mhz = 1'b0;
    forever #(period_ns / 2) clk_65mhz = ~clk_65mhz;
  end

  // held over the first edges, released just after an edge
  initial begin
    sys_rst = 1'b1;
    repeat (reset_cycles) @(posedge clk_65mhz);
    #1 sys_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_marker_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_marker_tracker;

  localparam int unsigned red_min   = 20;
  localparam int unsigned blue_min  = 20;
  localparam int unsigned green_max = 12;

  // small frames keep the run short
  localparam int frame_w         = 16;
  localparam int frame_h         = 12;
  localparam int frame_pixels    = frame_w * frame_h;
  localparam int directed_frames = 4;
  localparam int random_frames   = 20;
  localparam int frame_count     = directed_frames + random_frames;
  localparam int timeout_cycles  = frame_count * 300 + 500;

  typedef struct packed {
    logic                 red_found;
    tracker_pkg::hcount_t red_x;
    tracker_pkg::vcount_t red_y;
    logic                 blue_found;
    tracker_pkg::hcount_t blue_x;
    tracker_pkg::vcount_t blue_y;
    logic                 target_found;
    tracker_pkg::hcount_t target_x;
    tracker_pkg::vcount_t target_y;
  } report_t;

  logic                 clk_65mhz;
  logic                 sys_rst;
  logic                 pixel_valid;
  tracker_pkg::pixel_t  pixel;
  tracker_pkg::hcount_t hcount;
  tracker_pkg::vcount_t vcount;
  logic                 target_valid;
  logic                 target_found;
  tracker_pkg::hcount_t target_x;
  tracker_pkg::vcount_t target_y;
  logic                 red_found;
  tracker_pkg::hcount_t red_x;
  tracker_pkg::vcount_t red_y;
  logic                 blue_found;
  tracker_pkg::hcount_t blue_x;
  tracker_pkg::vcount_t blue_y;

  // frame being built and reports still owed by the DUT
  tracker_pkg::pixel_t  frame_pix [frame_pixels];
  report_t              expected_q[$];
  string                name_q[$];
  logic                 boundary_sent;

  tb_clock_gen #(.period_ns(4), .reset_cycles(5)) clock_gen (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst)
  );

  marker_tracker_top #(
    .red_min   (red_min),
    .blue_min  (blue_min),
    .green_max (green_max)
  ) uut (
    .clk_65mhz    (clk_65mhz),
    .sys_rst      (sys_rst),
    .pixel_valid  (pixel_valid),
    .pixel        (pixel),
    .hcount       (hcount),
    .vcount       (vcount),
    .target_valid (target_valid),
    .target_found (target_found),
    .target_x     (target_x),
    .target_y     (target_y),
    .red_found    (red_found),
    .red_x        (red_x),
    .red_y        (red_y),
    .blue_found   (blue_found),
    .blue_x       (blue_x),
    .blue_y       (blue_y)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // per-pixel classify then floor centroid per color and floor midpoint
  function automatic report_t reference_report(input tracker_pkg::pixel_t pix [frame_pixels]);
    report_t             r;
    int                  red_sx;
    int                  red_sy;
    int                  red_n;
    int                  blue_sx;
    int                  blue_sy;
    int                  blue_n;
    tracker_pkg::pixel_t p;
    r       = '0;
    red_sx  = 0;
    red_sy  = 0;
    red_n   = 0;
    blue_sx = 0;
    blue_sy = 0;
    blue_n  = 0;
    for (int y = 0; y < frame_h; y++) begin
      for (int x = 0; x < frame_w; x++) begin
        p = pix[y * frame_w + x];
        // green test on the top five of six green bits
        if ((int'(p[15:11]) >= red_min) && (int'(p[10:6]) < green_max)) begin
          red_sx += x;
          red_sy += y;
          red_n++;
        end
        if ((int'(p[4:0]) >= blue_min) && (int'(p[10:6]) < green_max)) begin
          blue_sx += x;
          blue_sy += y;
          blue_n++;
        end
      end
    end
    if (red_n > 0) begin
      r.red_found = 1'b1;
      r.red_x     = tracker_pkg::hcount_t'(red_sx / red_n);
      r.red_y     = tracker_pkg::vcount_t'(red_sy / red_n);
    end
    if (blue_n > 0) begin
      r.blue_found = 1'b1;
      r.blue_x     = tracker_pkg::hcount_t'(blue_sx / blue_n);
      r.blue_y     = tracker_pkg::vcount_t'(blue_sy / blue_n);
    end
    if (r.red_found && r.blue_found) begin
      r.target_found = 1'b1;
      r.target_x     = tracker_pkg::hcount_t'((int'(r.red_x) + int'(r.blue_x)) / 2);
      r.target_y     = tracker_pkg::vcount_t'((int'(r.red_y) + int'(r.blue_y)) / 2);
    end
    return r;
  endfunction

  function automatic tracker_pkg::pixel_t make_pixel(input int r, input int gtop,
                                                     input int glow, input int b);
    return {r[4:0], gtop[4:0], glow[0], b[4:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual)
      else fail_run($sformatf("mismatch %s %s expected %0d actual %0d",
                              test, field, expected, actual));
  endtask

  //////////////////////////////////////////////////////////////////////
  // frame builders
  //////////////////////////////////////////////////////////////////////

  // white background with green far above the limit
  task automatic fill_background();
    for (int i = 0; i < frame_pixels; i++) begin
      frame_pix[i] = make_pixel(31, 31, 1, 31);
    end
  endtask

  task automatic paint_rect(input int x0, input int y0, input int x1, input int y1,
                            input tracker_pkg::pixel_t p);
    for (int y = y0; y <= y1; y++) begin
      for (int x = x0; x <= x1; x++) begin
        frame_pix[y * frame_w + x] = p;
      end
    end
  endtask

  // mostly background with candidates near the thresholds
  task automatic fill_random();
    int kind;
    for (int i = 0; i < frame_pixels; i++) begin
      kind = $urandom % 8;
      if (kind == 0) begin
        frame_pix[i] = make_pixel(16 + $urandom % 16, 9 + $urandom % 5,
                                  $urandom % 2, $urandom % 32);
      end else if (kind == 1) begin
        frame_pix[i] = make_pixel($urandom % 32, 9 + $urandom % 5,
                                  $urandom % 2, 16 + $urandom % 16);
      end else if (kind == 2) begin
        frame_pix[i] = tracker_pkg::pixel_t'($urandom);
      end else begin
        frame_pix[i] = make_pixel($urandom % 32, 12 + $urandom % 20,
                                  $urandom % 2, $urandom % 32);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // pixel driver
  //////////////////////////////////////////////////////////////////////

  // origin with valid low must not open a frame
  task automatic idle_cycle();
    @(posedge clk_65mhz);
    #1;
    pixel_valid = 1'b0;
    pixel       = tracker_pkg::pixel_t'($urandom);
    hcount      = '0;
    vcount      = '0;
  endtask

  task automatic drive_pixel(input int x, input int y, input tracker_pkg::pixel_t p);
    int gap;
    gap = (($urandom % 16) == 0) ? 1 + $urandom % 3 : 0;
    repeat (gap) idle_cycle();
    @(posedge clk_65mhz);
    #1;
    pixel_valid = 1'b1;
    pixel       = p;
    hcount      = tracker_pkg::hcount_t'(x);
    vcount      = tracker_pkg::vcount_t'(y);
    if ((x == 0) && (y == 0)) begin
      boundary_sent = 1'b1;
    end
  endtask

  // expected report is owed once the next frame starts
  task automatic run_frame(input string name);
    expected_q.push_back(reference_report(frame_pix));
    name_q.push_back(name);
    for (int y = 0; y < frame_h; y++) begin
      for (int x = 0; x < frame_w; x++) begin
        drive_pixel(x, y, frame_pix[y * frame_w + x]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    void'($urandom(32'hb377_f154));
    pixel_valid   = 1'b0;
    pixel         = '0;
    hcount        = '0;
    vcount        = '0;
    boundary_sent = 1'b0;
    while (sys_rst !== 1'b0) begin
      @(posedge clk_65mhz);
    end
    // no report may appear in this quiet stretch
    repeat (20) idle_cycle();
    expected_q.push_back('0);
    name_q.push_back("reset_empty");

    fill_background();
    paint_rect(3, 2, 6, 5, make_pixel(31, 0, 0, 0));
    run_frame("red_only");

    fill_background();
    paint_rect(1, 1, 4, 3, make_pixel(28, 2, 0, 4));
    paint_rect(10, 7, 13, 9, make_pixel(0, 3, 1, 31));
    run_frame("both_markers");

    // channels exactly at the minimum and green exactly at the limit
    fill_background();
    frame_pix[1 * frame_w + 1]  = make_pixel(20, 11, 1, 0);
    frame_pix[1 * frame_w + 2]  = make_pixel(19, 0, 0, 0);
    frame_pix[1 * frame_w + 3]  = make_pixel(31, 12, 0, 0);
    frame_pix[4 * frame_w + 4]  = make_pixel(0, 11, 1, 20);
    frame_pix[4 * frame_w + 5]  = make_pixel(0, 0, 0, 19);
    frame_pix[4 * frame_w + 6]  = make_pixel(0, 12, 0, 31);
    frame_pix[8 * frame_w + 9]  = make_pixel(20, 11, 0, 20);
    frame_pix[11 * frame_w + 15] = make_pixel(31, 12, 1, 31);
    run_frame("thresholds");

    fill_background();
    run_frame("empty_after_hits");

    for (int i = 0; i < random_frames; i++) begin
      fill_random();
      run_frame($sformatf("random_%0d", i));
    end

    // lone origin pixel closes the last frame
    drive_pixel(0, 0, make_pixel(31, 31, 1, 31));
    idle_cycle();
    while (expected_q.size() != 0) begin
      @(posedge clk_65mhz);
    end
    // a stray extra report would be caught here
    repeat (60) @(posedge clk_65mhz);
    $display("*** PASSED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // comparison sampled mid cycle
  //////////////////////////////////////////////////////////////////////

  initial begin : compare_reports
    report_t exp_r;
    string   name;
    forever begin
      @(negedge clk_65mhz);
      if (target_valid === 1'b1) begin
        assert (boundary_sent)
          else fail_run("target_valid rose before the first frame boundary");
        assert (expected_q.size() > 0)
          else fail_run("target_valid pulsed with no frame left to report");
        exp_r = expected_q.pop_front();
        name  = name_q.pop_front();
        check_value(name, "red_found", 32'(exp_r.red_found), 32'(red_found));
        check_value(name, "red_x", 32'(exp_r.red_x), 32'(red_x));
        check_value(name, "red_y", 32'(exp_r.red_y), 32'(red_y));
        check_value(name, "blue_found", 32'(exp_r.blue_found), 32'(blue_found));
        check_value(name, "blue_x", 32'(exp_r.blue_x), 32'(blue_x));
        check_value(name, "blue_y", 32'(exp_r.blue_y), 32'(blue_y));
        check_value(name, "target_found", 32'(exp_r.target_found), 32'(target_found));
        check_value(name, "target_x", 32'(exp_r.target_x), 32'(target_x));
        check_value(name, "target_y", 32'(exp_r.target_y), 32'(target_y));
      end
    end
  end

  // bounded by the number of frames
  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk_65mhz);
    fail_run($sformatf("no result arrived in time, %0d reports still pending after %0d cycles",
                       expected_q.size(), timeout_cycles));
  end

endmodule

`default_nettype wire

//--- vlog.f
source/tracker_pkg.sv
source/pixel_classifier.sv
source/serial_divider.sv
source/centroid_tracker.sv
source/target_combiner.sv
source/marker_tracker_top.sv
testbench/tb_clock_gen.sv
testbench/tb_marker_tracker.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_marker_tracker
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= *** FAILED ***
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "test failed, no pass line"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
